// ==== common/spiPkg.sv ====
// Shared constants for the SPI master peripheral
// Register map, sizes, reset values and controller state codes
package spiPkg;

  // Bus and datapath sizes
  localparam int dataWidth    = 32;
  localparam int addrWidth    = 8;
  localparam int fifoDepthLog = 3;
  localparam int fifoDepth    = 1 << fifoDepthLog;
  localparam int frameWidth   = 8;
  localparam int lenWidth     = 4;
  localparam int sckDivWidth  = 12;

  // Byte offsets of the register map
  localparam logic [addrWidth-1:0] sckDivAddr  = 8'h00;
  localparam logic [addrWidth-1:0] sckModeAddr = 8'h04;
  localparam logic [addrWidth-1:0] csIdAddr    = 8'h10;
  localparam logic [addrWidth-1:0] csDefAddr   = 8'h14;
  localparam logic [addrWidth-1:0] csModeAddr  = 8'h18;
  localparam logic [addrWidth-1:0] fmtAddr     = 8'h40;
  localparam logic [addrWidth-1:0] txDataAddr  = 8'h48;
  localparam logic [addrWidth-1:0] rxDataAddr  = 8'h4C;
  localparam logic [addrWidth-1:0] txMarkAddr  = 8'h50;
  localparam logic [addrWidth-1:0] rxMarkAddr  = 8'h54;
  localparam logic [addrWidth-1:0] ieAddr      = 8'h70;
  localparam logic [addrWidth-1:0] ipAddr      = 8'h74;

  // Reset values
  localparam logic [sckDivWidth-1:0] sckDivReset = 12'd3;
  localparam logic [3:0]             csDefReset  = 4'b1111;
  localparam logic [lenWidth-1:0]    fmtLenReset = 4'd8;
  localparam logic [lenWidth-1:0]    frameLenMax = 4'd8;

  // Frame FSM states
  localparam logic [1:0] stIdle   = 2'd0;
  localparam logic [1:0] stLoad   = 2'd1;
  localparam logic [1:0] stShift  = 2'd2;
  localparam logic [1:0] stFinish = 2'd3;

endpackage

// ==== hdl/spiFifo.sv ====
// Synchronous byte FIFO with full and empty flags and watermark compare
`timescale 1ns/1ps

module spiFifo (
  input  logic                              PCLK,
  input  logic                              PRESETn,
  input  logic                              push,
  input  logic [spiPkg::frameWidth-1:0]     pushData,
  input  logic                              pop,
  input  logic [spiPkg::fifoDepthLog-1:0]   mark,
  output logic [spiPkg::frameWidth-1:0]     popData,
  output logic                              full,
  output logic                              empty,
  output logic                              belowMark,
  output logic                              aboveMark
);

  logic [spiPkg::frameWidth-1:0]  mem [spiPkg::fifoDepth];
  logic [spiPkg::fifoDepthLog:0]  wrPtr;
  logic [spiPkg::fifoDepthLog:0]  rdPtr;
  logic [spiPkg::fifoDepthLog:0]  count;
  logic                           doPush;
  logic                           doPop;

  // Extra pointer bit tells full from empty
  assign count = wrPtr - rdPtr;
  assign empty = (wrPtr == rdPtr);
  assign full  = (wrPtr[spiPkg::fifoDepthLog] != rdPtr[spiPkg::fifoDepthLog]) &&
                 (wrPtr[spiPkg::fifoDepthLog-1:0] == rdPtr[spiPkg::fifoDepthLog-1:0]);

  // Push on full or pop on empty is ignored
  assign doPush = push & ~full;
  assign doPop  = pop & ~empty;

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (doPush) wrPtr <= wrPtr + 1'b1;
      if (doPop)  rdPtr <= rdPtr + 1'b1;
    end
  end

  always_ff @(posedge PCLK) begin
    if (doPush) begin
      mem[wrPtr[spiPkg::fifoDepthLog-1:0]] <= pushData;
    end
  end

  // Head entry, no read latency
  assign popData = mem[rdPtr[spiPkg::fifoDepthLog-1:0]];

  // Watermarks, both strict
  assign belowMark = count < {1'b0, mark};
  assign aboveMark = count > {1'b0, mark};

  assert property (@(posedge PCLK) disable iff (!PRESETn)
    count <= (spiPkg::fifoDepthLog+1)'(spiPkg::fifoDepth))
    else $error("FIFO entry count above its depth");

endmodule

// ==== hdl/spiRegs.sv ====
// APB register file of the SPI master
// Control registers, FIFO strobes, interrupt pending bits and chip select
`timescale 1ns/1ps

module spiRegs (
  input  logic                              PCLK,
  input  logic                              PRESETn,
  input  logic                              PSEL,
  input  logic                              PENABLE,
  input  logic                              PWRITE,
  input  logic [spiPkg::addrWidth-1:0]      PADDR,
  input  logic [spiPkg::dataWidth-1:0]      PWDATA,
  input  logic                              txFull,
  input  logic                              txBelowMark,
  input  logic                              rxEmpty,
  input  logic                              rxAboveMark,
  input  logic [spiPkg::frameWidth-1:0]     rxPopData,
  input  logic                              frameActive,
  output logic                              PREADY,
  output logic [spiPkg::dataWidth-1:0]      PRDATA,
  output logic                              txPush,
  output logic [spiPkg::frameWidth-1:0]     txPushData,
  output logic                              rxPop,
  output logic [spiPkg::sckDivWidth-1:0]    sckDiv,
  output logic                              sckDivWrite,
  output logic [1:0]                        sckMode,
  output logic [spiPkg::lenWidth-1:0]       frameLen,
  output logic                              lsbFirst,
  output logic [spiPkg::fifoDepthLog-1:0]   txMark,
  output logic [spiPkg::fifoDepthLog-1:0]   rxMark,
  output logic [3:0]                        SPICS,
  output logic                              SPIIntr
);

  logic [1:0]                        csId;
  logic [3:0]                        csDef;
  logic [1:0]                        csMode;
  logic [1:0]                        ie;
  logic [1:0]                        ip;
  logic [spiPkg::addrWidth-1:0]      wordAddr;
  logic                              accessPhase;
  logic                              regWrite;
  logic [spiPkg::lenWidth-1:0]       wrLen;
  logic [spiPkg::lenWidth-1:0]       fmtLen;
  logic [spiPkg::dataWidth-1:0]      readData;
  logic [3:0]                        csAuto;

  ////////////////////
  // APB decode
  ////////////////////

  // Word access only, low address bits dropped
  assign wordAddr    = {PADDR[spiPkg::addrWidth-1:2], 2'b00};
  assign accessPhase = PSEL & PENABLE;
  assign regWrite    = accessPhase & PWRITE;
  assign PREADY      = 1'b1;

  // FIFO strobes, guarded by the flags
  assign txPush      = regWrite & (wordAddr == spiPkg::txDataAddr) & ~txFull;
  assign txPushData  = PWDATA[spiPkg::frameWidth-1:0];
  assign rxPop       = accessPhase & ~PWRITE & (wordAddr == spiPkg::rxDataAddr) & ~rxEmpty;
  assign sckDivWrite = regWrite & (wordAddr == spiPkg::sckDivAddr);

  // Unsupported lengths fall back to a full byte
  assign wrLen  = PWDATA[19:16];
  assign fmtLen = (wrLen == '0 || wrLen > spiPkg::frameLenMax) ? spiPkg::fmtLenReset : wrLen;

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      sckDiv   <= spiPkg::sckDivReset;
      sckMode  <= 2'b00;
      csId     <= 2'b00;
      csDef    <= spiPkg::csDefReset;
      csMode   <= 2'b00;
      frameLen <= spiPkg::fmtLenReset;
      lsbFirst <= 1'b0;
      txMark   <= '0;
      rxMark   <= '0;
      ie       <= 2'b00;
      ip       <= 2'b00;
    end else begin
      if (regWrite) begin
        case (wordAddr)
          spiPkg::sckDivAddr:  sckDiv  <= PWDATA[spiPkg::sckDivWidth-1:0];
          spiPkg::sckModeAddr: sckMode <= PWDATA[1:0];
          spiPkg::csIdAddr:    csId    <= PWDATA[1:0];
          spiPkg::csDefAddr:   csDef   <= PWDATA[3:0];
          spiPkg::csModeAddr:  csMode  <= PWDATA[1:0];
          spiPkg::fmtAddr: begin
            frameLen <= fmtLen;
            lsbFirst <= PWDATA[2];
          end
          spiPkg::txMarkAddr:  txMark  <= PWDATA[spiPkg::fifoDepthLog-1:0];
          spiPkg::rxMarkAddr:  rxMark  <= PWDATA[spiPkg::fifoDepthLog-1:0];
          spiPkg::ieAddr:      ie      <= PWDATA[1:0];
          default: ;
        endcase
      end
      // Pending bits track the watermarks every cycle
      ip <= {rxAboveMark, txBelowMark};
    end
  end

  ////////////////////
  // Read path
  ////////////////////

  always_comb begin
    case (wordAddr)
      spiPkg::sckDivAddr:  readData = {20'b0, sckDiv};
      spiPkg::sckModeAddr: readData = {30'b0, sckMode};
      spiPkg::csIdAddr:    readData = {30'b0, csId};
      spiPkg::csDefAddr:   readData = {28'b0, csDef};
      spiPkg::csModeAddr:  readData = {30'b0, csMode};
      spiPkg::fmtAddr:     readData = {12'b0, frameLen, 13'b0, lsbFirst, 2'b0};
      spiPkg::txDataAddr:  readData = {txFull, 31'b0};
      spiPkg::rxDataAddr:  readData = {rxEmpty, 23'b0, rxPopData};
      spiPkg::txMarkAddr:  readData = {29'b0, txMark};
      spiPkg::rxMarkAddr:  readData = {29'b0, rxMark};
      spiPkg::ieAddr:      readData = {30'b0, ie};
      spiPkg::ipAddr:      readData = {30'b0, ip};
      default:             readData = '0;
    endcase
  end

  // Captured in the setup phase, held through the access phase
  always_ff @(posedge PCLK) begin
    if (PSEL && !PENABLE) begin
      PRDATA <= readData;
    end
  end

  ////////////////////
  // Interrupt and chip select
  ////////////////////

  assign SPIIntr = |(ip & ie);

  // Auto mode flips only the selected line during a frame
  always_comb begin
    csAuto = csDef;
    if (frameActive) begin
      csAuto[csId] = ~csDef[csId];
    end
  end

  // Off mode hands the pins to CSDEF
  assign SPICS = (csMode == 2'd3) ? csDef : csAuto;

  // A popped byte must be the one the read returned
  assert property (@(posedge PCLK) disable iff (!PRESETn)
    rxPop |-> !PRDATA[spiPkg::dataWidth-1])
    else $error("RXDATA pop after a read that reported the receive FIFO empty");

  // Pushed byte comes from a complete TXDATA transfer
  assert property (@(posedge PCLK) disable iff (!PRESETn)
    txPush |-> $past(PSEL && !PENABLE && PWRITE && wordAddr == spiPkg::txDataAddr) &&
               $stable(PWDATA))
    else $error("TXDATA push without a matching APB setup phase");

endmodule

// ==== spiCore/spiController.sv ====
// Serial clock divider, frame bit counter and frame FSM
`timescale 1ns/1ps

module spiController (
  input  logic                              PCLK,
  input  logic                              PRESETn,
  input  logic [spiPkg::sckDivWidth-1:0]    sckDiv,
  input  logic                              sckDivWrite,
  input  logic [1:0]                        sckMode,
  input  logic [spiPkg::lenWidth-1:0]       frameLen,
  input  logic                              txEmpty,
  output logic                              txPop,
  output logic                              txLoad,
  output logic                              shiftEdge,
  output logic                              sampleEdge,
  output logic                              rxPush,
  output logic                              busy,
  output logic                              frameActive,
  output logic                              SPICLK
);

  logic [spiPkg::sckDivWidth-1:0]  divCnt;
  logic                            halfTick;
  logic [1:0]                      state;
  logic [1:0]                      nextState;
  logic [spiPkg::lenWidth-1:0]     halfCnt;
  logic [spiPkg::lenWidth:0]       halfLast;
  logic                            lastHalf;
  logic                            sclkPhase;
  logic                            shiftTick;
  logic                            leading;

  ////////////////////
  // Clock divider
  ////////////////////

  // One strobe per SPICLK half period, restart on SCKDIV write
  assign halfTick = (divCnt == sckDiv);

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      divCnt <= '0;
    end else if (sckDivWrite || halfTick) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  ////////////////////
  // Frame FSM
  ////////////////////

  // Two half periods per bit
  assign halfLast = {frameLen, 1'b0} - 1'b1;
  assign lastHalf = ({1'b0, halfCnt} == halfLast);

  always_comb begin
    nextState = state;
    case (state)
      spiPkg::stIdle:   if (!txEmpty) nextState = spiPkg::stLoad;
      // Load lines up with a divider strobe so the first half period is whole
      spiPkg::stLoad:   if (halfTick) nextState = spiPkg::stShift;
      spiPkg::stShift:  if (halfTick && lastHalf) nextState = spiPkg::stFinish;
      spiPkg::stFinish: nextState = txEmpty ? spiPkg::stIdle : spiPkg::stLoad;
      default:          nextState = spiPkg::stIdle;
    endcase
  end

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      state     <= spiPkg::stIdle;
      halfCnt   <= '0;
      sclkPhase <= 1'b0;
    end else begin
      state <= nextState;
      if (state != spiPkg::stShift) begin
        halfCnt   <= '0;
        sclkPhase <= 1'b0;
      end else if (halfTick) begin
        halfCnt   <= halfCnt + 1'b1;
        sclkPhase <= ~sclkPhase;
      end
    end
  end

  // Idle level follows CPOL
  assign SPICLK = sckMode[1] ^ sclkPhase;

  // Edge placement by CPHA
  // CPHA 0 samples leading, shifts trailing
  // CPHA 1 shifts leading (not the first), samples trailing
  assign shiftTick  = (state == spiPkg::stShift) && halfTick;
  assign leading    = ~halfCnt[0];
  assign sampleEdge = shiftTick && (sckMode[0] ? !leading : leading);
  assign shiftEdge  = shiftTick && (sckMode[0] ? (leading && halfCnt != '0) : !leading);

  assign txLoad      = (state == spiPkg::stLoad) && halfTick;
  assign txPop       = txLoad;
  assign rxPush      = (state == spiPkg::stFinish);
  assign busy        = (state == spiPkg::stShift);
  assign frameActive = (state != spiPkg::stIdle);

  // Whole periods per frame bring the clock back to CPOL
  assert property (@(posedge PCLK) disable iff (!PRESETn) !busy |-> SPICLK == sckMode[1])
    else $error("SPICLK away from its idle level outside the shift phase");

endmodule

// ==== spiCore/spiShifter.sv ====
// Transmit and receive shift registers
// Bit-order reversal and left alignment of short frames
`timescale 1ns/1ps

module spiShifter (
  input  logic                              PCLK,
  input  logic                              PRESETn,
  input  logic [spiPkg::frameWidth-1:0]     txPopData,
  input  logic                              txLoad,
  input  logic                              shiftEdge,
  input  logic                              sampleEdge,
  input  logic                              busy,
  input  logic [spiPkg::lenWidth-1:0]       frameLen,
  input  logic                              lsbFirst,
  input  logic                              SPIIn,
  output logic                              SPIOut,
  output logic [spiPkg::frameWidth-1:0]     rxPushData
);

  logic [spiPkg::frameWidth-1:0]  txOrdered;
  logic [spiPkg::frameWidth-1:0]  txShift;
  logic [spiPkg::frameWidth-1:0]  rxShift;
  logic [spiPkg::frameWidth-1:0]  rxAligned;
  logic [spiPkg::lenWidth-1:0]    alignAmt;

  function automatic logic [spiPkg::frameWidth-1:0] reverseBits(
    input logic [spiPkg::frameWidth-1:0] value
  );
    logic [spiPkg::frameWidth-1:0] result;
    for (int i = 0; i < spiPkg::frameWidth; i++) begin
      result[i] = value[spiPkg::frameWidth-1-i];
    end
    return result;
  endfunction

  // Always shifts MSB first, LSB-first data is reversed at load
  assign txOrdered = lsbFirst ? reverseBits(txPopData) : txPopData;

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      txShift <= '0;
    end else if (txLoad) begin
      txShift <= txOrdered;
    end else if (shiftEdge) begin
      txShift <= {txShift[spiPkg::frameWidth-2:0], 1'b0};
    end
  end

  // Line held low outside the clocked part of a frame
  assign SPIOut = busy & txShift[spiPkg::frameWidth-1];

  always_ff @(posedge PCLK) begin
    if (sampleEdge) begin
      rxShift <= {rxShift[spiPkg::frameWidth-2:0], SPIIn};
    end
  end

  // Short frames land in the low bits, move them to the top
  assign alignAmt   = spiPkg::frameLenMax - frameLen;
  assign rxAligned  = rxShift << alignAmt;
  assign rxPushData = lsbFirst ? reverseBits(rxAligned) : rxAligned;

endmodule

// ==== hdl/spiTop.sv ====
// Top level of the SPI master peripheral
// Register file, TX and RX FIFOs, frame controller and shifter
`timescale 1ns/1ps

module spiTop (
  input  logic                              PCLK,
  input  logic                              PRESETn,
  input  logic                              PSEL,
  input  logic                              PENABLE,
  input  logic                              PWRITE,
  input  logic [spiPkg::addrWidth-1:0]      PADDR,
  input  logic [spiPkg::dataWidth-1:0]      PWDATA,
  // Byte strobes accepted, registers are word access
  input  logic [spiPkg::dataWidth/8-1:0]    PSTRB,
  output logic                              PREADY,
  output logic [spiPkg::dataWidth-1:0]      PRDATA,
  output logic                              SPIOut,
  input  logic                              SPIIn,
  output logic [3:0]                        SPICS,
  output logic                              SPICLK,
  output logic                              SPIIntr
);

  logic                             txPush, txPop, txLoad, txFull, txEmpty, txBelowMark;
  logic                             rxPush, rxPop, rxEmpty, rxAboveMark;
  logic [spiPkg::frameWidth-1:0]    txPushData, txPopData, rxPushData, rxPopData;
  logic [spiPkg::sckDivWidth-1:0]   sckDiv;
  logic                             sckDivWrite;
  logic [1:0]                       sckMode;
  logic [spiPkg::lenWidth-1:0]      frameLen;
  logic                             lsbFirst;
  logic [spiPkg::fifoDepthLog-1:0]  txMark, rxMark;
  logic                             shiftEdge, sampleEdge, busy, frameActive;

  spiRegs regs (
    .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
    .txFull, .txBelowMark, .rxEmpty, .rxAboveMark, .rxPopData, .frameActive,
    .PREADY, .PRDATA, .txPush, .txPushData, .rxPop,
    .sckDiv, .sckDivWrite, .sckMode, .frameLen, .lsbFirst,
    .txMark, .rxMark, .SPICS, .SPIIntr
  );

  // TX side only needs the low watermark
  spiFifo txFifo (
    .PCLK, .PRESETn,
    .push(txPush), .pushData(txPushData), .pop(txPop), .mark(txMark),
    .popData(txPopData), .full(txFull), .empty(txEmpty),
    .belowMark(txBelowMark), .aboveMark()
  );

  // RX overflow drops the frame inside the FIFO
  spiFifo rxFifo (
    .PCLK, .PRESETn,
    .push(rxPush), .pushData(rxPushData), .pop(rxPop), .mark(rxMark),
    .popData(rxPopData), .full(), .empty(rxEmpty),
    .belowMark(), .aboveMark(rxAboveMark)
  );

  spiController controller (
    .PCLK, .PRESETn, .sckDiv, .sckDivWrite, .sckMode, .frameLen, .txEmpty,
    .txPop, .txLoad, .shiftEdge, .sampleEdge, .rxPush, .busy, .frameActive, .SPICLK
  );

  spiShifter shifter (
    .PCLK, .PRESETn, .txPopData, .txLoad, .shiftEdge, .sampleEdge, .busy,
    .frameLen, .lsbFirst, .SPIIn, .SPIOut, .rxPushData
  );

endmodule

// ==== dv/spiTb.sv ====
// Testbench for the SPI master peripheral
// APB tasks, loopback stimulus table, chip select and SPICLK monitors, watchdog
`timescale 1ns/1ps

module spiTb;

  localparam int numRows     = 16;
  localparam int pollLimit   = 200;
  localparam int intrLimit   = 400;
  localparam int extraFrames = spiPkg::fifoDepth + 2;
  localparam logic [31:0] randomSeed = 32'h9a4f_7d11;

  logic        PCLK;
  logic        PRESETn;
  logic        PSEL;
  logic        PENABLE;
  logic        PWRITE;
  logic [7:0]  PADDR;
  logic [31:0] PWDATA;
  logic [3:0]  PSTRB;
  logic        PREADY;
  logic [31:0] PRDATA;
  wire         spiLoop;
  logic [3:0]  SPICS;
  logic        SPICLK;
  logic        SPIIntr;

  ////////////////////
  // Stimulus table
  ////////////////////

  // One frame per row, data bytes and expected bytes filled at start
  int rowDiv  [numRows] = '{0, 1, 2, 3, 7, 0, 5, 1, 2, 4, 0, 6, 1, 3, 0, 2};
  int rowMode [numRows] = '{0, 1, 2, 3, 0, 1, 2, 3, 0, 1, 2, 3, 0, 1, 2, 3};
  int rowLen  [numRows] = '{8, 7, 6, 5, 4, 3, 2, 1, 1, 2, 3, 4, 5, 6, 7, 8};
  int rowLsb  [numRows] = '{0, 1, 0, 1, 1, 0, 1, 0, 1, 0, 1, 0, 0, 1, 0, 1};
  logic [7:0] rowData [numRows];
  logic [7:0] rowExp  [numRows];
  logic [7:0] flowData [spiPkg::fifoDepth+1];

  // Reset values, RXDATA only checked on its empty flag
  logic [7:0] resetAddr [12] = '{spiPkg::sckDivAddr, spiPkg::sckModeAddr, spiPkg::csIdAddr,
    spiPkg::csDefAddr, spiPkg::csModeAddr, spiPkg::fmtAddr, spiPkg::txDataAddr,
    spiPkg::rxDataAddr, spiPkg::txMarkAddr, spiPkg::rxMarkAddr, spiPkg::ieAddr,
    spiPkg::ipAddr};
  logic [31:0] resetExp [12] = '{32'h3, 32'h0, 32'h0, 32'hF, 32'h0, 32'h0008_0000, 32'h0,
    32'h8000_0000, 32'h0, 32'h0, 32'h0, 32'h0};
  logic [31:0] resetMask [12] = '{'1, '1, '1, '1, '1, '1, '1, 32'h8000_0000, '1, '1, '1, '1};

  // Writes carry junk above each field
  logic [7:0] rbAddr [9] = '{spiPkg::sckDivAddr, spiPkg::sckModeAddr, spiPkg::csIdAddr,
    spiPkg::csDefAddr, spiPkg::csModeAddr, spiPkg::fmtAddr, spiPkg::txMarkAddr,
    spiPkg::rxMarkAddr, spiPkg::ieAddr};
  logic [31:0] rbWrite [9] = '{32'hFFFF_FABC, 32'hFFFF_FFFE, 32'hFFFF_FFF3, 32'h0000_005A,
    32'h0000_0002, 32'h1235_0004, 32'h0000_000E, 32'h0000_0005, 32'hFFFF_FFFF};
  logic [31:0] rbExp [9] = '{32'hABC, 32'h2, 32'h3, 32'hA, 32'h2, 32'h0005_0004, 32'h6,
    32'h5, 32'h3};

  int mismatchCount  = 0;
  int failureCount   = 0;
  int csErrorCount   = 0;
  int csActiveCycles = 0;
  int sclkEdges      = 0;
  logic sclkPrev     = 1'b0;

  // Chip select expectations of the current row
  bit         csCheckOn = 1'b0;
  bit         csWindow  = 1'b0;
  logic [1:0] csIdExp   = 2'd0;
  logic [1:0] csModeExp = 2'd0;
  logic [3:0] csDefExp  = 4'hF;
  logic [3:0] csActive;

  // MOSI looped straight back to MISO
  spiTop i_spiTop (
    .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PSTRB,
    .PREADY, .PRDATA, .SPIOut(spiLoop), .SPIIn(spiLoop), .SPICS, .SPICLK, .SPIIntr
  );

  initial begin
    PCLK = 1'b0;
    forever #50 PCLK = ~PCLK;
  end

  function automatic logic [7:0] expectedByte(input logic [7:0] data, input int len,
                                               input bit lsb);
    logic [7:0] keep;
    // Bits past the frame length come back as zero
    if (lsb) keep = 8'hFF >> (8 - len);
    else keep = 8'hFF << (8 - len);
    return data & keep;
  endfunction

  task automatic reportMismatch(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
    mismatchCount++;
    $display("mismatch at %0t: %s, expected %h, got %h", $time, what, expected, actual);
  endtask

  task automatic reportFailure(input string what);
    failureCount++;
    $display("Error at %0t: %s", $time, what);
  endtask

  ////////////////////
  // APB access
  ////////////////////

  task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
    @(posedge PCLK);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b1;
    PADDR   <= addr;
    PWDATA  <= data;
    @(posedge PCLK);
    PENABLE <= 1'b1;
    // Write lands on this edge
    @(posedge PCLK);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
  endtask

  task automatic readReg(input logic [7:0] addr, output logic [31:0] data);
    @(posedge PCLK);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
    PADDR   <= addr;
    @(posedge PCLK);
    PENABLE <= 1'b1;
    // Mid access phase, PRDATA held since setup
    @(negedge PCLK);
    data = PRDATA;
    if (PREADY !== 1'b1) reportFailure("PREADY low during an access phase");
    @(posedge PCLK);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  // IP bit 1 with RXMARK 0 flags a received byte without popping it
  task automatic waitRxReady(output bit ready);
    logic [31:0] ipValue;
    ready = 1'b0;
    for (int n = 0; n < pollLimit && !ready; n++) begin
      readReg(spiPkg::ipAddr, ipValue);
      ready = ipValue[1];
    end
  endtask

  task automatic waitIntrLevel(input logic level, output bit reached);
    reached = 1'b0;
    for (int n = 0; n < intrLimit && !reached; n++) begin
      @(negedge PCLK);
      reached = (SPIIntr === level);
    end
  endtask

  ////////////////////
  // Chip select monitor
  ////////////////////

  assign csActive = csDefExp ^ (4'b0001 << csIdExp);

  // Auto mode frame window allows the chosen line flipped, else CSDEF exactly
  always @(negedge PCLK) begin
    if (csCheckOn) begin
      if (csWindow && csModeExp == 2'd0 && SPICS === csActive) begin
        csActiveCycles++;
      end else if (SPICS !== csDefExp) begin
        csErrorCount++;
        $display("mismatch at %0t: SPICS expected %b, got %b (CSID %0d, CSMODE %0d)",
                 $time, csDefExp, SPICS, csIdExp, csModeExp);
      end
    end
  end

  // SPICLK transitions seen while a row runs
  always @(negedge PCLK) begin
    if (csCheckOn && SPICLK !== sclkPrev) begin
      sclkEdges++;
    end
    sclkPrev = SPICLK;
  end

  initial begin
    logic [31:0] rd;
    bit          ready;
    int          activeBefore;
    int          edgesBefore;
    PRESETn = 1'b0;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    PSTRB   = 4'hF;
    void'($urandom(randomSeed));
    for (int i = 0; i < numRows; i++) begin
      rowData[i] = 8'($urandom);
      rowExp[i]  = expectedByte(rowData[i], rowLen[i], rowLsb[i] != 0);
    end
    repeat (5) @(posedge PCLK);
    PRESETn <= 1'b1;
    @(negedge PCLK);

    // Pins and registers straight out of reset
    if (SPICS !== 4'hF) reportMismatch("SPICS after reset", 32'hF, {28'b0, SPICS});
    if (SPIIntr !== 1'b0) reportFailure("SPIIntr is high after reset");
    if (SPICLK !== 1'b0) reportFailure("SPICLK is not at its idle level after reset");
    for (int r = 0; r < 12; r++) begin
      readReg(resetAddr[r], rd);
      if ((rd & resetMask[r]) !== resetExp[r]) begin
        reportMismatch($sformatf("reset value at offset %h", resetAddr[r]), resetExp[r],
                       rd & resetMask[r]);
      end
    end

    // Write all first, then read back
    for (int r = 0; r < 9; r++) begin
      writeReg(rbAddr[r], rbWrite[r]);
    end
    for (int r = 0; r < 9; r++) begin
      readReg(rbAddr[r], rd);
      if (rd !== rbExp[r]) begin
        reportMismatch($sformatf("readback at offset %h", rbAddr[r]), rbExp[r], rd);
      end
    end
    writeReg(spiPkg::txMarkAddr, 32'h0);
    writeReg(spiPkg::rxMarkAddr, 32'h0);
    writeReg(spiPkg::ieAddr, 32'h0);

    // Loopback rows, odd rows hold chip select in off mode
    for (int i = 0; i < numRows; i++) begin
      csCheckOn = 1'b0;
      csWindow  = 1'b0;
      csModeExp = (i % 2 == 1) ? 2'd3 : 2'd0;
      csIdExp   = 2'((i / 2) % 4);
      csDefExp  = 4'((i * 5 + 6) % 16);
      writeReg(spiPkg::sckDivAddr, 32'(rowDiv[i]));
      writeReg(spiPkg::sckModeAddr, 32'(rowMode[i]));
      writeReg(spiPkg::fmtAddr, (32'(rowLen[i]) << 16) | (32'(rowLsb[i]) << 2));
      writeReg(spiPkg::csIdAddr, {30'b0, csIdExp});
      writeReg(spiPkg::csDefAddr, {28'b0, csDefExp});
      writeReg(spiPkg::csModeAddr, {30'b0, csModeExp});
      activeBefore = csActiveCycles;
      edgesBefore  = sclkEdges;
      csCheckOn = 1'b1;
      csWindow  = 1'b1;
      writeReg(spiPkg::txDataAddr, {24'b0, rowData[i]});
      waitRxReady(ready);
      csWindow = 1'b0;
      if (!ready) begin
        reportFailure($sformatf("no receive data for table row %0d", i));
      end else begin
        readReg(spiPkg::rxDataAddr, rd);
        if (rd !== {24'b0, rowExp[i]}) begin
          reportMismatch($sformatf("RXDATA of table row %0d", i), {24'b0, rowExp[i]}, rd);
        end
      end
      if (csModeExp == 2'd0 && csActiveCycles == activeBefore) begin
        reportFailure($sformatf("chip select %0d never asserted in row %0d", csIdExp, i));
      end
      // One full SPICLK period per bit, then back at CPOL
      if (sclkEdges - edgesBefore != 2 * rowLen[i]) begin
        reportMismatch($sformatf("SPICLK edges in table row %0d", i), 32'(2 * rowLen[i]),
                       32'(sclkEdges - edgesBefore));
      end
      if (SPICLK !== 1'((rowMode[i] >> 1) & 1)) begin
        reportMismatch($sformatf("SPICLK idle level after table row %0d", i),
                       32'((rowMode[i] >> 1) & 1), {31'b0, SPICLK});
      end
    end
    csCheckOn = 1'b0;

    // Slowest clock keeps the TX FIFO full, the ninth byte is dropped
    writeReg(spiPkg::fmtAddr, 32'h0008_0000);
    writeReg(spiPkg::sckModeAddr, 32'h0);
    writeReg(spiPkg::sckDivAddr, 32'hFFF);
    for (int k = 0; k <= spiPkg::fifoDepth; k++) begin
      flowData[k] = 8'($urandom);
      writeReg(spiPkg::txDataAddr, {24'b0, flowData[k]});
    end
    readReg(spiPkg::txDataAddr, rd);
    if (rd[31] !== 1'b1) reportFailure("TXDATA did not report full after nine writes");
    writeReg(spiPkg::sckDivAddr, 32'h1);
    for (int k = 0; k < spiPkg::fifoDepth; k++) begin
      waitRxReady(ready);
      if (!ready) begin
        reportFailure($sformatf("no receive data for flow-control byte %0d", k));
      end else begin
        readReg(spiPkg::rxDataAddr, rd);
        if (rd !== {24'b0, expectedByte(flowData[k], 8, 1'b0)}) begin
          reportMismatch($sformatf("RXDATA of flow-control byte %0d", k),
                         {24'b0, flowData[k]}, rd);
        end
      end
    end
    readReg(spiPkg::rxDataAddr, rd);
    if (rd[31] !== 1'b1) reportFailure("RXDATA not empty after all bytes were drained");

    // Receive watermark interrupt
    writeReg(spiPkg::rxMarkAddr, 32'h0);
    writeReg(spiPkg::txMarkAddr, 32'h0);
    writeReg(spiPkg::ieAddr, 32'h2);
    writeReg(spiPkg::txDataAddr, 32'h0000_00C3);
    waitIntrLevel(1'b1, ready);
    if (!ready) reportFailure("SPIIntr did not rise after a frame was received");
    readReg(spiPkg::rxDataAddr, rd);
    if (rd !== 32'h0000_00C3) reportMismatch("RXDATA in the interrupt test", 32'hC3, rd);
    waitIntrLevel(1'b0, ready);
    if (!ready) reportFailure("SPIIntr stayed high after RXDATA was drained");

    // Transmit watermark interrupt, TX FIFO empty
    writeReg(spiPkg::txMarkAddr, 32'h1);
    writeReg(spiPkg::ieAddr, 32'h1);
    waitIntrLevel(1'b1, ready);
    if (!ready) reportFailure("SPIIntr stayed low with an empty TX FIFO under TXMARK 1");
    writeReg(spiPkg::ieAddr, 32'h0);
    waitIntrLevel(1'b0, ready);
    if (!ready) reportFailure("SPIIntr stayed high after IE was cleared");

    $display("Run complete: %0d value mismatches, %0d chip select errors, %0d other failures",
             mismatchCount, csErrorCount, failureCount);
    if (mismatchCount + csErrorCount + failureCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Budget of two slowest frames per row plus the flow and interrupt frames
  initial begin
    int maxDiv;
    int limit;
    maxDiv = 0;
    foreach (rowDiv[i]) begin
      if (rowDiv[i] > maxDiv) maxDiv = rowDiv[i];
    end
    limit = (numRows + extraFrames) * 16 * 2 * (maxDiv + 1) + 2000;
    repeat (limit) @(posedge PCLK);
    $display("Watchdog expired after %0d clock cycles before the tests finished", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== spiPeriph.f ====
common/spiPkg.sv
hdl/spiFifo.sv
hdl/spiRegs.sv
spiCore/spiController.sv
spiCore/spiShifter.sv
hdl/spiTop.sv
dv/spiTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the SPI peripheral testbench with Verilator and runs it into a log
cd "$(dirname "$0")" || exit 1

simLog=sim.log

verilator --binary --assert -Wno-fatal --top-module spiTb \
  -f spiPeriph.f --Mdir build -o spiSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./build/spiSim > "$simLog" 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see $simLog"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" "$simLog"; then
  echo "Testbench passed, log in $simLog"
  exit 0
fi
echo "Testbench failed, log in $simLog"
exit 1
